// File: rtl/calc_pkg.sv
// operands are three BCD digits plus sign; result magnitude must fit MAG_W bits and six digits
`default_nettype none

package calc_pkg;

    localparam int DIGIT_W    = 4;
    localparam int NUM_DIGITS = 3;
    localparam int RES_DIGITS = 6;
    localparam int MAG_W      = 20;
    localparam int OP_W       = 3;

    // display codes beyond the decimal digits
    localparam logic [DIGIT_W-1:0] CODE_BLANK = 4'd10;
    localparam logic [DIGIT_W-1:0] CODE_MINUS = 4'd11;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic mid;
    } button_t;

    typedef struct packed {
        logic                                sign;
        logic [NUM_DIGITS-1:0][DIGIT_W-1:0] digits;
    } operand_t;

    typedef struct packed {
        logic                                neg;
        logic                                invalid;
        logic [RES_DIGITS-1:0][DIGIT_W-1:0] digits;
    } result_t;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_MUL,
        OP_NONE
    } op_e;

    typedef enum logic [2:0] {
        S_IDLE,
        S_INPUT_A,
        S_INPUT_B,
        S_EXEC,
        S_CONVERT,
        S_DISPLAY
    } ctrl_state_e;

    typedef enum logic [2:0] {
        CUR_IDLE,
        CUR_D0,
        CUR_D1,
        CUR_D2,
        CUR_SIGN
    } cursor_e;

    // active low segments, bit 0 is the decimal point
    function automatic logic [7:0] seg_encode(logic [DIGIT_W-1:0] code);
        case (code)
            4'd0:       return 8'b0000_0011;
            4'd1:       return 8'b1001_1111;
            4'd2:       return 8'b0010_0101;
            4'd3:       return 8'b0000_1101;
            4'd4:       return 8'b1001_1001;
            4'd5:       return 8'b0100_1001;
            4'd6:       return 8'b0100_0001;
            4'd7:       return 8'b0001_1111;
            4'd8:       return 8'b0000_0001;
            4'd9:       return 8'b0001_1001;
            CODE_MINUS: return 8'b1111_1101;
            default:    return 8'b1111_1111;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: rtl/button_conditioner.sv
// one pulse per press after DEBOUNCE_CYCLES of stable input; a held higher button masks lower ones
`timescale 1ns/10ps
`default_nettype none

module button_conditioner #(
    parameter int DEBOUNCE_CYCLES = 250000
) (
    input  logic              clk,
    input  logic              rst_n,
    input  calc_pkg::button_t buttons_raw,
    output calc_pkg::button_t buttons
);
    import calc_pkg::*;

    localparam int N_BTN = $bits(button_t);
    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    button_t                     level;
    button_t                     level_q;
    logic [N_BTN-1:0][CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level   <= '0;
            level_q <= '0;
            cnt     <= '0;
        end else begin
            level_q <= level;
            for (int i = 0; i < N_BTN; i++) begin
                if (buttons_raw[i] == level[i]) begin
                    cnt[i] <= '0;
                end else if (cnt[i] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                    level[i] <= buttons_raw[i];
                    cnt[i]   <= '0;
                end else begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    // left > right > up > down > mid
    always_comb begin
        buttons.left  = level.left & ~level_q.left;
        buttons.right = level.right & ~level_q.right & ~level.left;
        buttons.up    = level.up & ~level_q.up & ~(level.left | level.right);
        buttons.down  = level.down & ~level_q.down & ~(level.left | level.right | level.up);
        buttons.mid   = level.mid & ~level_q.mid
                        & ~(level.left | level.right | level.up | level.down);
    end

endmodule

`default_nettype wire

// File: rtl/operand_entry.sv
// buttons act only while entry_active; entry_clear wins over any press in the same cycle
`timescale 1ns/10ps
`default_nettype none

module operand_entry (
    input  logic               clk,
    input  logic               rst_n,
    input  calc_pkg::button_t  buttons,
    input  logic               entry_active,
    input  logic               entry_clear,
    output calc_pkg::operand_t operand,
    output calc_pkg::cursor_e  cursor
);
    import calc_pkg::*;

    logic [1:0]         sel;
    logic [DIGIT_W-1:0] cur_digit;
    logic [DIGIT_W-1:0] new_digit;

    // digit under the cursor, stepped modulo 10
    always_comb begin
        case (cursor)
            CUR_D1:  sel = 2'd1;
            CUR_D2:  sel = 2'd2;
            default: sel = 2'd0;
        endcase
        cur_digit = operand.digits[sel];
        if (buttons.up)
            new_digit = (cur_digit == DIGIT_W'(9)) ? '0 : cur_digit + 1'b1;
        else
            new_digit = (cur_digit == '0) ? DIGIT_W'(9) : cur_digit - 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cursor  <= CUR_IDLE;
            operand <= '0;
        end else if (entry_clear) begin
            cursor  <= CUR_D0;
            operand <= '0;
        end else if (entry_active) begin
            // saturates at D0 and SIGN
            case (cursor)
                CUR_D0: begin
                    if (buttons.left)
                        cursor <= CUR_D1;
                end
                CUR_D1: begin
                    if (buttons.left)
                        cursor <= CUR_D2;
                    else if (buttons.right)
                        cursor <= CUR_D0;
                end
                CUR_D2: begin
                    if (buttons.left)
                        cursor <= CUR_SIGN;
                    else if (buttons.right)
                        cursor <= CUR_D1;
                end
                CUR_SIGN: begin
                    if (buttons.right)
                        cursor <= CUR_D2;
                end
                default: cursor <= CUR_IDLE;
            endcase
            if (buttons.up || buttons.down) begin
                if (cursor == CUR_SIGN)
                    operand.sign <= ~operand.sign;
                else if (cursor != CUR_IDLE)
                    operand.digits[sel] <= new_digit;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/calc_control.sv
// buttons are ignored in S_EXEC and S_CONVERT; an invalid result leaves display on any mid
`timescale 1ns/10ps
`default_nettype none

module calc_control (
    input  logic                        clk,
    input  logic                        rst_n,
    input  calc_pkg::button_t           buttons,
    input  calc_pkg::operand_t          operand,
    input  logic [calc_pkg::OP_W-1:0]   op_switches,
    input  logic                        alu_done,
    input  logic                        invalid,
    input  logic                        bcd_done,
    output logic                        entry_active,
    output logic                        entry_clear,
    output logic                        alu_start,
    output logic                        bcd_start,
    output calc_pkg::operand_t          operand_a,
    output calc_pkg::operand_t          operand_b,
    output calc_pkg::op_e               op,
    output calc_pkg::ctrl_state_e       state,
    output logic                        page,
    output logic                        exe_done,
    output logic [2:0]                  display_stage
);
    import calc_pkg::*;

    op_e op_dec;

    // lowest set switch wins
    always_comb begin
        if (op_switches[0])
            op_dec = OP_ADD;
        else if (op_switches[1])
            op_dec = OP_SUB;
        else if (op_switches[2])
            op_dec = OP_MUL;
        else
            op_dec = OP_NONE;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            page        <= 1'b0;
            op          <= OP_NONE;
            entry_clear <= 1'b0;
            alu_start   <= 1'b0;
            bcd_start   <= 1'b0;
        end else begin
            entry_clear <= 1'b0;
            alu_start   <= 1'b0;
            bcd_start   <= 1'b0;
            case (state)
                S_IDLE: begin
                    state       <= S_INPUT_A;
                    entry_clear <= 1'b1;
                end
                S_INPUT_A: begin
                    if (buttons.mid) begin
                        state       <= S_INPUT_B;
                        entry_clear <= 1'b1;
                    end
                end
                S_INPUT_B: begin
                    if (buttons.mid) begin
                        state       <= S_EXEC;
                        op          <= op_dec;
                        entry_clear <= 1'b1;
                        alu_start   <= 1'b1;
                    end
                end
                S_EXEC: begin
                    if (alu_done) begin
                        state     <= S_CONVERT;
                        bcd_start <= 1'b1;
                    end
                end
                S_CONVERT: begin
                    if (bcd_done) begin
                        state <= S_DISPLAY;
                        page  <= 1'b0;
                    end
                end
                S_DISPLAY: begin
                    if (buttons.mid && (page || invalid)) begin
                        state       <= S_INPUT_A;
                        page        <= 1'b0;
                        entry_clear <= 1'b1;
                    end else if (buttons.mid) begin
                        page <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // operand capture on mid
    always_ff @(posedge clk) begin
        if (state == S_INPUT_A && buttons.mid)
            operand_a <= operand;
        if (state == S_INPUT_B && buttons.mid)
            operand_b <= operand;
    end

    assign entry_active  = (state == S_INPUT_A) || (state == S_INPUT_B);
    assign exe_done      = (state == S_DISPLAY);
    assign display_stage = exe_done ? {2'b00, page} + 3'd1 : 3'd0;

endmodule

`default_nettype wire

// File: rtl/int_alu.sv
// add, sub and mul of signed 3-digit operands; results stay valid until the next start
`timescale 1ns/10ps
`default_nettype none

module int_alu (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  calc_pkg::operand_t           operand_a,
    input  calc_pkg::operand_t           operand_b,
    input  calc_pkg::op_e                op,
    output logic [calc_pkg::MAG_W-1:0]   magnitude,
    output logic                         neg,
    output logic                         invalid,
    output logic                         done
);
    import calc_pkg::*;

    // one extra bit for the sign
    localparam int VAL_W = MAG_W + 1;

    logic signed [VAL_W-1:0] val_a;
    logic signed [VAL_W-1:0] val_b;
    logic signed [VAL_W-1:0] res;
    logic signed [VAL_W-1:0] res_abs;

    function automatic logic signed [VAL_W-1:0] to_value(operand_t opd);
        logic signed [VAL_W-1:0] mag;
        mag = VAL_W'(opd.digits[2]) * 100 + VAL_W'(opd.digits[1]) * 10 + VAL_W'(opd.digits[0]);
        return opd.sign ? -mag : mag;
    endfunction

    assign val_a = to_value(operand_a);
    assign val_b = to_value(operand_b);

    always_comb begin
        case (op)
            OP_ADD:  res = val_a + val_b;
            OP_SUB:  res = val_a - val_b;
            OP_MUL:  res = val_a * val_b;
            default: res = '0;
        endcase
    end

    assign res_abs = res[VAL_W-1] ? -res : res;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done    <= 1'b0;
            neg     <= 1'b0;
            invalid <= 1'b0;
        end else begin
            done <= start;
            if (start) begin
                neg     <= res[VAL_W-1];
                invalid <= (op == OP_NONE);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            magnitude <= res_abs[MAG_W-1:0];
    end

endmodule

`default_nettype wire

// File: rtl/bin2bcd.sv
// done pulses MAG_W + 1 cycles after start; magnitude must be held during conversion
`timescale 1ns/10ps
`default_nettype none

module bin2bcd (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic                                               start,
    input  logic [calc_pkg::MAG_W-1:0]                         magnitude,
    output logic [calc_pkg::RES_DIGITS-1:0][calc_pkg::DIGIT_W-1:0] digits,
    output logic                                               done
);
    import calc_pkg::*;

    localparam int CNT_W = $clog2(MAG_W + 1);

    logic [MAG_W-1:0]                     bin;
    logic [RES_DIGITS-1:0][DIGIT_W-1:0]   adj;
    logic [CNT_W-1:0]                     cnt;

    // add 3 to any digit of 5 or more before the shift
    always_comb begin
        for (int i = 0; i < RES_DIGITS; i++) begin
            if (digits[i] >= DIGIT_W'(5))
                adj[i] = digits[i] + DIGIT_W'(3);
            else
                adj[i] = digits[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                cnt <= CNT_W'(MAG_W);
            end else if (cnt != '0) begin
                cnt  <= cnt - 1'b1;
                done <= (cnt == CNT_W'(1));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            bin    <= magnitude;
            digits <= '0;
        end else if (cnt != '0) begin
            {digits, bin} <= {adj, bin} << 1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/seg_display.sv
// no leading-zero suppression; all digits dark before the first scan tick and while busy
`timescale 1ns/10ps
`default_nettype none

module seg_display #(
    parameter int SCAN_DIV_BITS = 10
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  calc_pkg::ctrl_state_e state,
    input  calc_pkg::operand_t    operand,
    input  calc_pkg::result_t     result,
    input  logic                  page,
    output logic [3:0]            digit_ctrl,
    output logic [7:0]            digit_seg
);
    import calc_pkg::*;

    logic [SCAN_DIV_BITS-1:0] div;
    logic [1:0]               idx;
    logic                     scan_on;
    logic                     entry;
    logic                     blank;
    logic [2:0]               res_idx;
    logic [DIGIT_W-1:0]       code;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div     <= '0;
            idx     <= '0;
            scan_on <= 1'b0;
        end else begin
            div <= div + 1'b1;
            if (&div) begin
                scan_on <= 1'b1;
                if (scan_on)
                    idx <= idx + 1'b1;
            end
        end
    end

    assign entry = (state == S_INPUT_A) || (state == S_INPUT_B);
    assign blank = !scan_on || !(entry || state == S_DISPLAY)
                   || (state == S_DISPLAY && result.invalid);

    assign digit_ctrl = blank ? 4'b1111 : ~(4'b0001 << idx);

    // page 0 holds d5..d3, page 1 holds d2..d0
    assign res_idx = {1'b0, idx} + (page ? 3'd0 : 3'd3);

    always_comb begin
        code = CODE_BLANK;
        if (entry) begin
            if (idx == 2'd3)
                code = operand.sign ? CODE_MINUS : CODE_BLANK;
            else
                code = operand.digits[idx];
        end else if (state == S_DISPLAY) begin
            if (idx == 2'd3)
                code = (result.neg && !page) ? CODE_MINUS : CODE_BLANK;
            else
                code = result.digits[res_idx];
        end
    end

    assign digit_seg = seg_encode(code);

endmodule

`default_nettype wire

// File: rtl/cal_top.sv
// buttons are raw board inputs; debounce and scan rates come from the two parameters
`timescale 1ns/10ps
`default_nettype none

module cal_top #(
    parameter int DEBOUNCE_CYCLES = 250000,
    parameter int SCAN_DIV_BITS   = 10
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  calc_pkg::button_t         board_cal_button,
    input  logic [calc_pkg::OP_W-1:0] board_cal_switchs,
    output logic [3:0]                cal_board_digit_ctrl,
    output logic [7:0]                cal_board_digit_seg,
    output logic                      cal_board_exe_done,
    output logic [2:0]                cal_board_display_stage
);
    import calc_pkg::*;

    button_t                            buttons;
    operand_t                           operand;
    operand_t                           operand_a;
    operand_t                           operand_b;
    ctrl_state_e                        state;
    op_e                                op;
    result_t                            result;
    logic                               entry_active;
    logic                               entry_clear;
    logic                               alu_start;
    logic                               alu_done;
    logic                               bcd_start;
    logic                               bcd_done;
    logic                               page;
    logic                               neg;
    logic                               invalid;
    logic [MAG_W-1:0]                   magnitude;
    logic [RES_DIGITS-1:0][DIGIT_W-1:0] bcd_digits;

    button_conditioner #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) u_button_conditioner (
        .clk         (clk),
        .rst_n       (rst_n),
        .buttons_raw (board_cal_button),
        .buttons     (buttons)
    );

    operand_entry u_operand_entry (
        .clk          (clk),
        .rst_n        (rst_n),
        .buttons      (buttons),
        .entry_active (entry_active),
        .entry_clear  (entry_clear),
        .operand      (operand),
        .cursor       ()
    );

    calc_control u_calc_control (
        .clk           (clk),
        .rst_n         (rst_n),
        .buttons       (buttons),
        .operand       (operand),
        .op_switches   (board_cal_switchs),
        .alu_done      (alu_done),
        .invalid       (invalid),
        .bcd_done      (bcd_done),
        .entry_active  (entry_active),
        .entry_clear   (entry_clear),
        .alu_start     (alu_start),
        .bcd_start     (bcd_start),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .op            (op),
        .state         (state),
        .page          (page),
        .exe_done      (cal_board_exe_done),
        .display_stage (cal_board_display_stage)
    );

    int_alu u_int_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (alu_start),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .op        (op),
        .magnitude (magnitude),
        .neg       (neg),
        .invalid   (invalid),
        .done      (alu_done)
    );

    bin2bcd u_bin2bcd (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (bcd_start),
        .magnitude (magnitude),
        .digits    (bcd_digits),
        .done      (bcd_done)
    );

    assign result = '{neg: neg, invalid: invalid, digits: bcd_digits};

    seg_display #(
        .SCAN_DIV_BITS(SCAN_DIV_BITS)
    ) u_seg_display (
        .clk        (clk),
        .rst_n      (rst_n),
        .state      (state),
        .operand    (operand),
        .result     (result),
        .page       (page),
        .digit_ctrl (cal_board_digit_ctrl),
        .digit_seg  (cal_board_digit_seg)
    );

endmodule

`default_nettype wire

// File: sim/cal_sva.sv
// bound to cal_top and uses its internal operand net; checks are off during reset
`timescale 1ns/10ps
`default_nettype none

module cal_sva (
    input logic               clk,
    input logic               rst_n,
    input logic [3:0]         digit_ctrl,
    input logic               exe_done,
    input logic [2:0]         display_stage,
    input calc_pkg::operand_t operand
);
    import calc_pkg::*;

    a_one_digit: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(~digit_ctrl)
    ) else $error("more than one display digit enabled");

    a_stage_idle: assert property (
        @(posedge clk) disable iff (!rst_n) !exe_done |-> display_stage == 3'd0
    ) else $error("display stage set while no result is shown");

    // every entry digit stays BCD
    for (genvar i = 0; i < NUM_DIGITS; i++) begin : g_digit
        a_bcd: assert property (
            @(posedge clk) disable iff (!rst_n) operand.digits[i] <= DIGIT_W'(9)
        ) else $error("operand digit %0d above 9", i);
    end

endmodule

bind cal_top cal_sva sva_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .digit_ctrl    (cal_board_digit_ctrl),
    .exe_done      (cal_board_exe_done),
    .display_stage (cal_board_display_stage),
    .operand       (operand)
);

`default_nettype wire

// File: sim/cal_tb.sv
// short debounce and scan counts keep the run fast; the run stops at the first mismatch
`timescale 1ns/10ps
`default_nettype none

module cal_tb;
    import calc_pkg::*;

    localparam int      TIMEOUT_CYCLES = 20000;
    localparam button_t BTN_UP         = 5'b10000;
    localparam button_t BTN_DOWN       = 5'b01000;
    localparam button_t BTN_LEFT       = 5'b00100;
    localparam button_t BTN_RIGHT      = 5'b00010;
    localparam button_t BTN_MID        = 5'b00001;

    logic            clk;
    logic            rst_n;
    button_t         buttons;
    logic [OP_W-1:0] switches;
    logic [3:0]      digit_ctrl;
    logic [7:0]      digit_seg;
    logic            exe_done;
    logic [2:0]      display_stage;

    int    seed;
    int    cycles;
    string test_name;
    int    shown [4];

    cal_top #(
        .DEBOUNCE_CYCLES(4),
        .SCAN_DIV_BITS  (2)
    ) dut_i (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .board_cal_button        (buttons),
        .board_cal_switchs       (switches),
        .cal_board_digit_ctrl    (digit_ctrl),
        .cal_board_digit_seg     (digit_seg),
        .cal_board_exe_done      (exe_done),
        .cal_board_display_stage (display_stage)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

    task automatic check_eq(string label, int expected, int actual);
        if (expected != actual) begin
            $display("CHECK FAILED %s: %s expected %0d actual %0d",
                     test_name, label, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    // active low a..g, dp in bit 0
    function automatic int seg_to_code(logic [7:0] seg);
        case (seg)
            8'b0000_0011: return 0;
            8'b1001_1111: return 1;
            8'b0010_0101: return 2;
            8'b0000_1101: return 3;
            8'b1001_1001: return 4;
            8'b0100_1001: return 5;
            8'b0100_0001: return 6;
            8'b0001_1111: return 7;
            8'b0000_0001: return 8;
            8'b0001_1001: return 9;
            8'b1111_1111: return 10;
            8'b1111_1101: return 11;
            default:      return 15;
        endcase
    endfunction

    // lowest set switch picks the operation
    function automatic int expected_value(int va, int vb, logic [2:0] sw);
        if (sw[0])
            return va + vb;
        else if (sw[1])
            return va - vb;
        else
            return va * vb;
    endfunction

    task automatic press_button(button_t b);
        @(posedge clk);
        buttons <= b;
        repeat (8) @(posedge clk);
        buttons <= '0;
        repeat (8) @(posedge clk);
    endtask

    task automatic read_display();
        int         pos;
        logic [3:0] target;
        for (pos = 0; pos < 4; pos++) begin
            target = ~(4'b0001 << pos);
            @(negedge clk);
            while (digit_ctrl !== target)
                @(negedge clk);
            shown[pos] = seg_to_code(digit_seg);
        end
    endtask

    // codes listed from the leftmost digit
    task automatic expect_display(string label, int c3, int c2, int c1, int c0);
        int exp_codes [4];
        int i;
        exp_codes = '{c0, c1, c2, c3};
        read_display();
        for (i = 0; i < 4; i++)
            check_eq($sformatf("%s digit %0d", label, i), exp_codes[i], shown[i]);
    endtask

    task automatic wait_exe_done();
        @(negedge clk);
        while (!exe_done)
            @(negedge clk);
    endtask

    // expects cursor on D0 with a cleared operand
    task automatic enter_operand(int value, bit sign);
        int d [3];
        int i;
        d[0] = value % 10;
        d[1] = (value / 10) % 10;
        d[2] = value / 100;
        for (i = 0; i < 3; i++) begin
            if (d[i] <= 5)
                repeat (d[i]) press_button(BTN_UP);
            else
                repeat (10 - d[i]) press_button(BTN_DOWN);
            press_button(BTN_LEFT);
        end
        if (sign)
            press_button(BTN_UP);
        expect_display("operand", sign ? int'(CODE_MINUS) : int'(CODE_BLANK),
                       d[2], d[1], d[0]);
    endtask

    task automatic verify_result(int value);
        int mag;
        int sign_code;
        int d [6];
        int i;
        mag       = (value < 0) ? -value : value;
        sign_code = (value < 0) ? int'(CODE_MINUS) : int'(CODE_BLANK);
        for (i = 0; i < 6; i++) begin
            d[i] = mag % 10;
            mag  = mag / 10;
        end
        @(negedge clk);
        check_eq("stage on page 0", 1, display_stage);
        expect_display("page 0", sign_code, d[5], d[4], d[3]);
        press_button(BTN_MID);
        @(negedge clk);
        check_eq("stage on page 1", 2, display_stage);
        expect_display("page 1", int'(CODE_BLANK), d[2], d[1], d[0]);
        press_button(BTN_MID);
        @(negedge clk);
        check_eq("exe_done after paging", 0, exe_done);
        check_eq("stage after paging", 0, display_stage);
    endtask

    task automatic run_calc(int a, bit sa, int b, bit sb, logic [2:0] sw);
        int va;
        int vb;
        va = sa ? -a : a;
        vb = sb ? -b : b;
        enter_operand(a, sa);
        press_button(BTN_MID);
        enter_operand(b, sb);
        @(posedge clk);
        switches <= sw;
        press_button(BTN_MID);
        wait_exe_done();
        verify_result(expected_value(va, vb, sw));
    endtask

    task automatic reset_state_check();
        test_name = "reset";
        @(negedge clk);
        check_eq("exe_done", 0, exe_done);
        check_eq("display_stage", 0, display_stage);
        check_eq("digit_ctrl before scan", 15, digit_ctrl);
        expect_display("entry after reset", int'(CODE_BLANK), 0, 0, 0);
    endtask

    task automatic entry_edit();
        test_name = "entry";
        // down from 0 wraps to 9
        press_button(BTN_DOWN);
        press_button(BTN_LEFT);
        press_button(BTN_UP);
        press_button(BTN_UP);
        press_button(BTN_LEFT);
        press_button(BTN_LEFT);
        press_button(BTN_UP);
        expect_display("edited", int'(CODE_MINUS), 0, 2, 9);
    endtask

    task automatic priority_mask();
        test_name = "priority";
        press_button(BTN_RIGHT);
        press_button(BTN_LEFT | BTN_UP);
        // cursor should now sit on the sign
        press_button(BTN_UP);
        expect_display("left with up", int'(CODE_BLANK), 0, 2, 9);
    endtask

    task automatic invalid_op();
        test_name = "invalid";
        press_button(BTN_MID);
        @(posedge clk);
        switches <= '0;
        press_button(BTN_MID);
        wait_exe_done();
        check_eq("display_stage", 1, display_stage);
        repeat (16) begin
            @(negedge clk);
            check_eq("digit_ctrl dark", 15, digit_ctrl);
        end
        press_button(BTN_MID);
        @(negedge clk);
        check_eq("exe_done after mid", 0, exe_done);
        check_eq("display_stage after mid", 0, display_stage);
        expect_display("entry after invalid", int'(CODE_BLANK), 0, 0, 0);
    endtask

    task automatic add_sub_cases();
        int n;
        int rnd;
        int a;
        int b;
        test_name = "add_sub";
        run_calc(123, 1'b0, 456, 1'b0, 3'b001);
        run_calc(45, 1'b1, 300, 1'b0, 3'b010);
        run_calc(999, 1'b1, 999, 1'b1, 3'b001);
        for (n = 0; n < 4; n++) begin
            rnd = $random(seed);
            a   = {$random(seed)} % 1000;
            b   = {$random(seed)} % 1000;
            run_calc(a, rnd[0], b, rnd[1], rnd[2] ? 3'b010 : 3'b001);
        end
    endtask

    task automatic multiply_cases();
        test_name = "multiply";
        run_calc(999, 1'b0, 999, 1'b0, 3'b100);
        run_calc(37, 1'b1, 205, 1'b0, 3'b100);
    endtask

    initial begin
        buttons  = '0;
        switches = '0;
        rst_n    = 1'b0;
        seed     = 32'h64ddec5d;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        reset_state_check();
        entry_edit();
        priority_mask();
        invalid_op();
        add_sub_cases();
        multiply_cases();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/calc_pkg.sv
rtl/button_conditioner.sv
rtl/operand_entry.sv
rtl/calc_control.sv
rtl/int_alu.sv
rtl/bin2bcd.sv
rtl/seg_display.sv
rtl/cal_top.sv
sim/cal_sva.sv
sim/cal_tb.sv

// File: Bender.yml
package:
  name: board_calc

sources:
  - rtl/calc_pkg.sv
  - rtl/button_conditioner.sv
  - rtl/operand_entry.sv
  - rtl/calc_control.sv
  - rtl/int_alu.sv
  - rtl/bin2bcd.sv
  - rtl/seg_display.sv
  - rtl/cal_top.sv
  - target: simulation
    files:
      - sim/cal_sva.sv
      - sim/cal_tb.sv
